// ==== bpu_pkg.sv ====
package bpu_pkg;

	//******************************
	// counter encoding
	//******************************

	// width of pattern and chooser counters
	localparam int CTR_BITS = 2;

	// weakly not taken
	localparam logic [CTR_BITS-1:0] CTR_INIT = 2'b01;

	// chooser below midpoint selects global, so weakly global
	localparam logic [CTR_BITS-1:0] CHOICE_INIT = 2'b01;

	//******************************
	// counter helpers
	//******************************

	// saturating step toward the outcome
	function automatic logic [CTR_BITS-1:0] ctr_next(
		input logic [CTR_BITS-1:0] ctr,
		input logic                taken
	);
		logic [CTR_BITS-1:0] result;
		result = ctr;
		if (taken && (ctr != {CTR_BITS{1'b1}})) begin
			result = ctr + 1'b1;
		end else if (!taken && (ctr != {CTR_BITS{1'b0}})) begin
			result = ctr - 1'b1;
		end
		return result;
	endfunction

	// upper half of the range means taken
	function automatic logic ctr_taken(input logic [CTR_BITS-1:0] ctr);
		return ctr[CTR_BITS-1];
	endfunction

endpackage

// ==== local_predictor.sv ====
module local_predictor
	import bpu_pkg::*;
#(
	parameter int PC_WIDTH   = 32,
	parameter int INDEX_BITS = 6
) (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic [PC_WIDTH-1:0] lookup_pc_i,
	input  logic                train_valid_i,
	input  logic [PC_WIDTH-1:0] train_pc_i,
	input  logic                train_taken_i,
	output logic                local_taken_o
);

	localparam int TABLE_SIZE = 1 << INDEX_BITS;

	// per-pc history, then a pattern table addressed by that history
	logic [INDEX_BITS-1:0] lht [TABLE_SIZE];
	logic [CTR_BITS-1:0]   lpt [TABLE_SIZE];

	logic [INDEX_BITS-1:0] lookup_idx;
	logic [INDEX_BITS-1:0] lookup_hist;
	logic [INDEX_BITS-1:0] train_idx;
	logic [INDEX_BITS-1:0] train_hist;

	//******************************
	// lookup
	//******************************

	// skip the two word-offset bits
	assign lookup_idx  = lookup_pc_i[INDEX_BITS+1:2];
	assign lookup_hist = lht[lookup_idx];

	assign local_taken_o = ctr_taken(lpt[lookup_hist]);

	//******************************
	// training
	//******************************

	assign train_idx  = train_pc_i[INDEX_BITS+1:2];
	assign train_hist = lht[train_idx];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < TABLE_SIZE; i++) begin
				lht[i] <= '0;
				lpt[i] <= CTR_INIT;
			end
		end else if (train_valid_i) begin
			// counter picked by the history as it was before this outcome
			lpt[train_hist] <= ctr_next(lpt[train_hist], train_taken_i);
			lht[train_idx]  <= {train_hist[INDEX_BITS-2:0], train_taken_i};
		end
	end

endmodule

// ==== global_predictor.sv ====
module global_predictor
	import bpu_pkg::*;
#(
	parameter int PC_WIDTH   = 32,
	parameter int INDEX_BITS = 6
) (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [PC_WIDTH-1:0]   lookup_pc_i,
	input  logic                  train_valid_i,
	input  logic [PC_WIDTH-1:0]   train_pc_i,
	input  logic [INDEX_BITS-1:0] train_history_i,
	input  logic                  train_taken_i,
	output logic                  global_taken_o,
	output logic [INDEX_BITS-1:0] history_o
);

	localparam int TABLE_SIZE = 1 << INDEX_BITS;

	logic [INDEX_BITS-1:0] ghr_q;
	logic [CTR_BITS-1:0]   gpt [TABLE_SIZE];

	logic [INDEX_BITS-1:0] lookup_idx;
	logic [INDEX_BITS-1:0] train_idx;

	//******************************
	// gshare lookup
	//******************************

	assign lookup_idx = lookup_pc_i[INDEX_BITS+1:2] ^ ghr_q;

	assign global_taken_o = ctr_taken(gpt[lookup_idx]);
	// snapshot goes down the queue with the prediction
	assign history_o      = ghr_q;

	//******************************
	// training
	//******************************

	// same slot the prediction read, via the stored snapshot
	assign train_idx = train_pc_i[INDEX_BITS+1:2] ^ train_history_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ghr_q <= '0;
			for (int i = 0; i < TABLE_SIZE; i++) begin
				gpt[i] <= CTR_INIT;
			end
		end else if (train_valid_i) begin
			gpt[train_idx] <= ctr_next(gpt[train_idx], train_taken_i);
			// history only moves on resolved outcomes
			ghr_q <= {ghr_q[INDEX_BITS-2:0], train_taken_i};
		end
	end

endmodule

// ==== tournament_select.sv ====
module tournament_select
	import bpu_pkg::*;
#(
	parameter int PC_WIDTH   = 32,
	parameter int INDEX_BITS = 6
) (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                req_valid_i,
	input  logic [PC_WIDTH-1:0] req_pc_i,
	input  logic                local_taken_i,
	input  logic                global_taken_i,
	input  logic                train_valid_i,
	input  logic [PC_WIDTH-1:0] train_pc_i,
	input  logic                train_local_i,
	input  logic                train_global_i,
	input  logic                train_taken_i,
	output logic                choice_taken_o,
	output logic                pred_valid_o,
	output logic                pred_taken_o
);

	localparam int TABLE_SIZE = 1 << INDEX_BITS;

	// high half favours local, low half favours global
	logic [CTR_BITS-1:0] chooser [TABLE_SIZE];

	logic [INDEX_BITS-1:0] req_idx;
	logic [INDEX_BITS-1:0] train_idx;
	logic                  local_right;

	//******************************
	// selection
	//******************************

	assign req_idx = req_pc_i[INDEX_BITS+1:2];

	assign choice_taken_o = ctr_taken(chooser[req_idx]) ? local_taken_i : global_taken_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pred_valid_o <= 1'b0;
		end else begin
			pred_valid_o <= req_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		pred_taken_o <= choice_taken_o;
	end

	//******************************
	// chooser training
	//******************************

	assign train_idx   = train_pc_i[INDEX_BITS+1:2];
	assign local_right = (train_local_i == train_taken_i);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < TABLE_SIZE; i++) begin
				chooser[i] <= CHOICE_INIT;
			end
		end else if (train_valid_i && (train_local_i != train_global_i)) begin
			// exactly one side was right here
			chooser[train_idx] <= ctr_next(chooser[train_idx], local_right);
		end
	end

endmodule

// ==== branch_commit_queue.sv ====
module branch_commit_queue
	import bpu_pkg::*;
#(
	parameter int PC_WIDTH    = 32,
	parameter int INDEX_BITS  = 6,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  push_i,
	input  logic [PC_WIDTH-1:0]   push_pc_i,
	input  logic [INDEX_BITS-1:0] push_history_i,
	input  logic                  push_local_i,
	input  logic                  push_global_i,
	input  logic                  push_choice_i,
	input  logic                  res_valid_i,
	input  logic                  res_taken_i,
	output logic                  train_valid_o,
	output logic [PC_WIDTH-1:0]   train_pc_o,
	output logic [INDEX_BITS-1:0] train_history_o,
	output logic                  train_local_o,
	output logic                  train_global_o,
	output logic                  train_taken_o,
	output logic                  credit_o,
	output logic                  commit_o,
	output logic [PC_WIDTH-1:0]   commit_pc_o,
	output logic                  commit_taken_o,
	output logic                  commit_predict_o,
	output logic                  commit_hit_o,
	output logic                  commit_local_hit_o,
	output logic                  commit_global_hit_o
);

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	// metadata that used to ride the pipeline registers
	logic [PC_WIDTH-1:0]   q_pc      [QUEUE_DEPTH];
	logic [INDEX_BITS-1:0] q_history [QUEUE_DEPTH];
	logic                  q_local   [QUEUE_DEPTH];
	logic                  q_global  [QUEUE_DEPTH];
	logic                  q_choice  [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] head_q;
	logic [PTR_BITS-1:0] tail_q;
	logic [CNT_BITS-1:0] count_q;

	logic empty;
	logic full;
	logic push_ok;
	logic pop_ok;

	assign empty   = (count_q == '0);
	assign full    = (count_q == CNT_BITS'(QUEUE_DEPTH));
	assign push_ok = push_i && !full;
	assign pop_ok  = res_valid_i && !empty;

	//******************************
	// pointers and occupancy
	//******************************

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (push_ok) begin
				tail_q <= (tail_q == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : tail_q + 1'b1;
			end
			if (pop_ok) begin
				head_q <= (head_q == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : head_q + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// entry storage
	always_ff @(posedge clk_i) begin
		if (push_ok) begin
			q_pc[tail_q]      <= push_pc_i;
			q_history[tail_q] <= push_history_i;
			q_local[tail_q]   <= push_local_i;
			q_global[tail_q]  <= push_global_i;
			q_choice[tail_q]  <= push_choice_i;
		end
	end

	//******************************
	// training bus from head
	//******************************

	assign train_valid_o   = pop_ok;
	assign train_pc_o      = q_pc[head_q];
	assign train_history_o = q_history[head_q];
	assign train_local_o   = q_local[head_q];
	assign train_global_o  = q_global[head_q];
	assign train_taken_o   = res_taken_i;

	//******************************
	// commit report
	//******************************

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			commit_o <= 1'b0;
		end else begin
			commit_o <= pop_ok;
		end
	end

	// one credit back per retired entry, same cycle as the report
	assign credit_o = commit_o;

	always_ff @(posedge clk_i) begin
		if (pop_ok) begin
			commit_pc_o         <= q_pc[head_q];
			commit_taken_o      <= res_taken_i;
			commit_predict_o    <= q_choice[head_q];
			commit_hit_o        <= (q_choice[head_q] == res_taken_i);
			commit_local_hit_o  <= (q_local[head_q] == res_taken_i);
			commit_global_hit_o <= (q_global[head_q] == res_taken_i);
		end
	end

endmodule

// ==== bpu_top.sv ====
module bpu_top
	import bpu_pkg::*;
#(
	parameter int PC_WIDTH    = 32,
	parameter int INDEX_BITS  = 6,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                req_valid_i,
	input  logic [PC_WIDTH-1:0] req_pc_i,
	input  logic                res_valid_i,
	input  logic                res_taken_i,
	output logic                credit_o,
	output logic                pred_valid_o,
	output logic                pred_taken_o,
	output logic                commit_o,
	output logic [PC_WIDTH-1:0] commit_pc_o,
	output logic                commit_taken_o,
	output logic                commit_predict_o,
	output logic                commit_hit_o,
	output logic                commit_local_hit_o,
	output logic                commit_global_hit_o
);

	//******************************
	// lookup path
	//******************************
	logic                  local_taken;
	logic                  global_taken;
	logic [INDEX_BITS-1:0] global_history;
	logic                  choice_taken;

	//******************************
	// training bus
	//******************************
	logic                  train_valid;
	logic [PC_WIDTH-1:0]   train_pc;
	logic [INDEX_BITS-1:0] train_history;
	logic                  train_local;
	logic                  train_global;
	logic                  train_taken;

	local_predictor #(
		.PC_WIDTH   (PC_WIDTH),
		.INDEX_BITS (INDEX_BITS)
	) u_local (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.lookup_pc_i   (req_pc_i),
		.train_valid_i (train_valid),
		.train_pc_i    (train_pc),
		.train_taken_i (train_taken),
		.local_taken_o (local_taken)
	);

	global_predictor #(
		.PC_WIDTH   (PC_WIDTH),
		.INDEX_BITS (INDEX_BITS)
	) u_global (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.lookup_pc_i     (req_pc_i),
		.train_valid_i   (train_valid),
		.train_pc_i      (train_pc),
		.train_history_i (train_history),
		.train_taken_i   (train_taken),
		.global_taken_o  (global_taken),
		.history_o       (global_history)
	);

	tournament_select #(
		.PC_WIDTH   (PC_WIDTH),
		.INDEX_BITS (INDEX_BITS)
	) u_select (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.req_valid_i    (req_valid_i),
		.req_pc_i       (req_pc_i),
		.local_taken_i  (local_taken),
		.global_taken_i (global_taken),
		.train_valid_i  (train_valid),
		.train_pc_i     (train_pc),
		.train_local_i  (train_local),
		.train_global_i (train_global),
		.train_taken_i  (train_taken),
		.choice_taken_o (choice_taken),
		.pred_valid_o   (pred_valid_o),
		.pred_taken_o   (pred_taken_o)
	);

	branch_commit_queue #(
		.PC_WIDTH    (PC_WIDTH),
		.INDEX_BITS  (INDEX_BITS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk_i               (clk_i),
		.reset_i             (reset_i),
		.push_i              (req_valid_i),
		.push_pc_i           (req_pc_i),
		.push_history_i      (global_history),
		.push_local_i        (local_taken),
		.push_global_i       (global_taken),
		.push_choice_i       (choice_taken),
		.res_valid_i         (res_valid_i),
		.res_taken_i         (res_taken_i),
		.train_valid_o       (train_valid),
		.train_pc_o          (train_pc),
		.train_history_o     (train_history),
		.train_local_o       (train_local),
		.train_global_o      (train_global),
		.train_taken_o       (train_taken),
		.credit_o            (credit_o),
		.commit_o            (commit_o),
		.commit_pc_o         (commit_pc_o),
		.commit_taken_o      (commit_taken_o),
		.commit_predict_o    (commit_predict_o),
		.commit_hit_o        (commit_hit_o),
		.commit_local_hit_o  (commit_local_hit_o),
		.commit_global_hit_o (commit_global_hit_o)
	);

endmodule

// ==== bpu_top_assert.sv ====
module bpu_top_assert #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk_i,
	input logic reset_i,
	input logic req_valid_i,
	input logic res_valid_i,
	input logic credit_i
);

	// occupancy as the branch source sees it
	int outstanding;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + (req_valid_i ? 1 : 0) - (res_valid_i ? 1 : 0);
		end
	end

	resolve_needs_entry: assert property (@(posedge clk_i) disable iff (reset_i)
		res_valid_i |-> (outstanding > 0))
		else $error("resolution with an empty queue");

	push_needs_space: assert property (@(posedge clk_i) disable iff (reset_i)
		req_valid_i |-> (outstanding < QUEUE_DEPTH))
		else $error("request with a full queue");

	credit_follows_resolve: assert property (@(posedge clk_i) disable iff (reset_i)
		credit_i == $past(res_valid_i))
		else $error("credit not exactly one cycle after a resolution");

endmodule

bind bpu_top bpu_top_assert #(
	.QUEUE_DEPTH (QUEUE_DEPTH)
) u_protocol_check (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.req_valid_i (req_valid_i),
	.res_valid_i (res_valid_i),
	.credit_i    (credit_o)
);

// ==== bpu_model.svh ====
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

// one in-flight prediction, as the queue holds it
typedef struct packed {
	logic [PC_WIDTH-1:0]   pc;
	logic [INDEX_BITS-1:0] history;
	logic                  local_bit;
	logic                  global_bit;
	logic                  choice;
} flight_t;

// reference copies of every table, the global history and the queue
logic [INDEX_BITS-1:0] ref_lht [TABLE_SIZE];
logic [1:0]            ref_lpt [TABLE_SIZE];
logic [1:0]            ref_gpt [TABLE_SIZE];
logic [1:0]            ref_choose [TABLE_SIZE];
logic [INDEX_BITS-1:0] ref_ghr;
flight_t               ref_queue [$];

// two-bit counter moved one step, clamped to 0..3
function automatic logic [1:0] bump(input logic [1:0] ctr, input logic up);
	int level;
	level = int'(ctr) + (up ? 1 : -1);
	if (level < 0) begin
		level = 0;
	end else if (level > 3) begin
		level = 3;
	end
	return 2'(level);
endfunction

task automatic clear_tables();
	for (int i = 0; i < TABLE_SIZE; i++) begin
		ref_lht[i] = '0;
		// weakly not taken, chooser weakly global
		ref_lpt[i]    = 2'b01;
		ref_gpt[i]    = 2'b01;
		ref_choose[i] = 2'b01;
	end
	ref_ghr = '0;
	ref_queue.delete();
endtask

// reads the state as it stood before this cycle's training
task automatic lookup_branch(input logic [PC_WIDTH-1:0] pc, output logic taken);
	flight_t               e;
	logic [INDEX_BITS-1:0] idx;
	idx          = pc[INDEX_BITS+1:2];
	e.pc         = pc;
	e.history    = ref_ghr;
	e.local_bit  = ref_lpt[ref_lht[idx]][1];
	e.global_bit = ref_gpt[idx ^ ref_ghr][1];
	e.choice     = ref_choose[idx][1] ? e.local_bit : e.global_bit;
	ref_queue.push_back(e);
	taken = e.choice;
endtask

task automatic retire_branch(input logic taken, output flight_t e);
	logic [INDEX_BITS-1:0] idx;
	logic [INDEX_BITS-1:0] hist;
	e    = ref_queue.pop_front();
	idx  = e.pc[INDEX_BITS+1:2];
	hist = ref_lht[idx];
	ref_lpt[hist] = bump(ref_lpt[hist], taken);
	ref_lht[idx]  = {hist[INDEX_BITS-2:0], taken};
	ref_gpt[idx ^ e.history] = bump(ref_gpt[idx ^ e.history], taken);
	ref_ghr = {ref_ghr[INDEX_BITS-2:0], taken};
	// chooser only learns when the sides disagreed
	if (e.local_bit != e.global_bit) begin
		ref_choose[idx] = bump(ref_choose[idx], e.local_bit == taken);
	end
endtask

`endif

// ==== bpu_top_tb.sv ====
module bpu_top_tb;

	localparam int          PC_WIDTH       = 32;
	localparam int          INDEX_BITS     = 6;
	localparam int          QUEUE_DEPTH    = 4;
	localparam int          TABLE_SIZE     = 1 << INDEX_BITS;
	localparam int          NUM_OPS        = 400;
	localparam int          TIMEOUT_CYCLES = 8 * NUM_OPS + 100;
	localparam int          POOL_SIZE      = 8;
	localparam logic [31:0] SEED           = 32'h095613fc;

	logic                clk_i;
	logic                reset_i;
	logic                req_valid_i;
	logic [PC_WIDTH-1:0] req_pc_i;
	logic                res_valid_i;
	logic                res_taken_i;
	logic                credit_o;
	logic                pred_valid_o;
	logic                pred_taken_o;
	logic                commit_o;
	logic [PC_WIDTH-1:0] commit_pc_o;
	logic                commit_taken_o;
	logic                commit_predict_o;
	logic                commit_hit_o;
	logic                commit_local_hit_o;
	logic                commit_global_hit_o;

	`include "bpu_model.svh"

	// what the outputs must show one cycle after each drive
	logic    exp_pred_valid;
	logic    exp_pred_taken;
	logic    exp_commit;
	logic    exp_taken;
	flight_t exp_entry;

	logic [PC_WIDTH-1:0] pool_pc [POOL_SIZE];
	logic                alt_phase;
	int                  credits;
	int                  issued;
	int                  late_taken;
	int                  alt_local_hits;
	int                  cycle_count = 0;

	bpu_top #(
		.PC_WIDTH    (PC_WIDTH),
		.INDEX_BITS  (INDEX_BITS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) UUT (
		.clk_i               (clk_i),
		.reset_i             (reset_i),
		.req_valid_i         (req_valid_i),
		.req_pc_i            (req_pc_i),
		.res_valid_i         (res_valid_i),
		.res_taken_i         (res_taken_i),
		.credit_o            (credit_o),
		.pred_valid_o        (pred_valid_o),
		.pred_taken_o        (pred_taken_o),
		.commit_o            (commit_o),
		.commit_pc_o         (commit_pc_o),
		.commit_taken_o      (commit_taken_o),
		.commit_predict_o    (commit_predict_o),
		.commit_hit_o        (commit_hit_o),
		.commit_local_hit_o  (commit_local_hit_o),
		.commit_global_hit_o (commit_global_hit_o)
	);

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: requests still unresolved after %0d cycles", cycle_count);
			$display("Test failed");
			$fatal(1, "simulation timeout");
		end
	end

	//******************************
	// checking
	//******************************

	task automatic check_value(
		input string       name,
		input logic [31:0] actual,
		input logic [31:0] expected
	);
		if (actual !== expected) begin
			$display("ERROR time %0t: %s is %0h, expected %0h",
				$time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_outputs();
		check_value("pred_valid_o", 32'(pred_valid_o), 32'(exp_pred_valid));
		if (exp_pred_valid) begin
			check_value("pred_taken_o", 32'(pred_taken_o), 32'(exp_pred_taken));
		end
		check_value("commit_o", 32'(commit_o), 32'(exp_commit));
		check_value("credit_o", 32'(credit_o), 32'(exp_commit));
		if (exp_commit) begin
			check_value("commit_pc_o", commit_pc_o, exp_entry.pc);
			check_value("commit_taken_o", 32'(commit_taken_o), 32'(exp_taken));
			check_value("commit_predict_o", 32'(commit_predict_o), 32'(exp_entry.choice));
			check_value("commit_hit_o", 32'(commit_hit_o),
				32'(exp_entry.choice == exp_taken));
			check_value("commit_local_hit_o", 32'(commit_local_hit_o),
				32'(exp_entry.local_bit == exp_taken));
			check_value("commit_global_hit_o", 32'(commit_global_hit_o),
				32'(exp_entry.global_bit == exp_taken));
			// a taken local hit needs a trained pattern counter
			if ((commit_pc_o == pool_pc[1]) && commit_local_hit_o && commit_taken_o) begin
				alt_local_hits++;
			end
		end
	endtask

	//******************************
	// stimulus
	//******************************

	// slot 0 always taken, slot 1 alternates, 2 and 3 biased, rest random
	task automatic pick_outcome(input logic [PC_WIDTH-1:0] pc, output logic taken);
		taken = ($urandom % 2) == 0;
		if (pc == pool_pc[0]) begin
			taken = 1'b1;
		end else if (pc == pool_pc[1]) begin
			alt_phase = !alt_phase;
			taken     = alt_phase;
		end else if (pc == pool_pc[2]) begin
			taken = ($urandom % 8) != 0;
		end else if (pc == pool_pc[3]) begin
			taken = ($urandom % 8) == 0;
		end
	endtask

	task automatic drive_cycle();
		logic                do_req;
		logic                do_res;
		logic                pred;
		logic                taken;
		logic [PC_WIDTH-1:0] pc;
		flight_t             done;
		int                  slot;
		pred  = 1'b0;
		taken = 1'b0;
		done  = '0;
		pc    = $urandom & ~32'h3;
		// resolution decided on the queue as it stood before this request
		do_req = (issued < NUM_OPS) && (credits > 0) && (($urandom % 3) != 0);
		do_res = (ref_queue.size() > 0) && (($urandom % 2) == 0);
		if (do_req) begin
			slot = int'($urandom % POOL_SIZE);
			pc   = pool_pc[slot];
			lookup_branch(pc, pred);
			credits--;
			issued++;
			if ((slot == 0) && (issued > NUM_OPS / 2) && pred) begin
				late_taken++;
			end
		end
		if (do_res) begin
			pick_outcome(ref_queue[0].pc, taken);
			retire_branch(taken, done);
		end
		req_valid_i    = do_req;
		req_pc_i       = pc;
		res_valid_i    = do_res;
		res_taken_i    = taken;
		exp_pred_valid = do_req;
		exp_pred_taken = pred;
		exp_commit     = do_res;
		exp_taken      = taken;
		exp_entry      = done;
	endtask

	initial begin
		void'($urandom(SEED));
		clk_i          = 1'b0;
		reset_i        = 1'b1;
		req_valid_i    = 1'b0;
		req_pc_i       = '0;
		res_valid_i    = 1'b0;
		res_taken_i    = 1'b0;
		exp_pred_valid = 1'b0;
		exp_pred_taken = 1'b0;
		exp_commit     = 1'b0;
		exp_taken      = 1'b0;
		exp_entry      = '0;
		alt_phase      = 1'b0;
		credits        = QUEUE_DEPTH;
		issued         = 0;
		late_taken     = 0;
		alt_local_hits = 0;
		// distinct table index per slot so the learning branches stay apart
		for (int k = 0; k < POOL_SIZE; k++) begin
			pool_pc[k] = ($urandom & 32'hffff_ff00) | (32'(k * 7 + 3) << 2);
		end
		clear_tables();

		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b0;

		// quiet after reset
		repeat (4) begin
			@(negedge clk_i);
			check_outputs();
		end

		while ((issued < NUM_OPS) || (ref_queue.size() > 0)) begin
			@(negedge clk_i);
			check_outputs();
			if (credit_o) begin
				credits++;
			end
			drive_cycle();
		end

		@(negedge clk_i);
		check_outputs();
		req_valid_i    = 1'b0;
		res_valid_i    = 1'b0;
		exp_pred_valid = 1'b0;
		exp_commit     = 1'b0;
		@(negedge clk_i);
		check_outputs();

		if ((late_taken == 0) || (alt_local_hits == 0)) begin
			$display("always-taken branch never predicted taken late in the run,");
			$display("or alternating branch never reported a local hit on a taken outcome");
			$display("Test failed");
			$fatal(1, "predictors did not learn");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// ==== bpu_top.f ====
+incdir+.
bpu_pkg.sv
local_predictor.sv
global_predictor.sv
tournament_select.sv
branch_commit_queue.sv
bpu_top.sv
bpu_top_assert.sv
bpu_top_tb.sv

// ==== Makefile ====
TOP = bpu_top_tb
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f bpu_top.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f bpu_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
